// ==== lsu_input.txt ====
// tag 1 mem word: addr data | tag 2 reg word: reg word data | 4 expect reg: reg word data
// tag 3 op: store stride eew emul vl base stride vd stall | 5 expect mem: addr data | 0 end
1 d0 cafef00d
2 9 1 12345678
// unit-stride byte load into v2 and v3
3 0 0 0 1 1f 40 0 2 0
4 2 0 43424140
4 2 3 4f4e4d4c
4 3 0 53525150
4 3 3 5f5e5d5c
// strided halfword load, vl covers three elements
3 0 1 1 0 5 80 8 4 0
4 4 0 89888180
4 4 1 47469190
4 4 3 4f4e4d4c
4 5 0 53525150
// unit-stride word store, vl ends at byte 9
3 1 0 2 0 9 c0 0 6 0
5 c0 63626160
5 c4 67666564
5 c8 cbca6968
5 cc cfcecdcc
// strided byte store with stride 3
3 1 1 0 0 f 10 3 7 0
5 0c 0f0e0d0c
5 10 71121170
5 14 17721514
5 18 1b1a7318
5 3c 3f3e7f3c
// back-to-back load and store with random stalls
3 0 0 1 0 f d0 0 8 1
3 1 1 2 0 7 e0 8 9 1
4 8 0 cafef00d
4 8 3 dfdedddc
5 e0 93929190
5 e4 e7e6e5e4
5 e8 12345678
5 f0 f3f2f1f0
0

// ==== sources.f ====
lsu_pkg.sv
lsu_addr_gen.sv
lsu_req_queue.sv
lsu_load_writeback.sv
vector_lsu.sv
tb_mem_model.sv
tb_vector_lsu.sv

// ==== tb_vector_lsu.sv ====
/* testbench of the vector load/store unit with vectors from lsu_input.txt
   the register file model is written per beat and read combinationally */
`default_nettype none

module tb_vector_lsu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_WORDS = 512;

    logic         clk;
    logic         rst_n;
    logic         op_rdy;
    logic         op_ack;
    logic         store;
    logic         stride_mode;
    logic [1:0]   eew;
    logic [1:0]   emul;
    logic [6:0]   vl;
    logic [31:0]  base;
    logic [31:0]  stride;
    logic [4:0]   vd;
    logic         mem_valid;
    logic         mem_ready;
    logic [31:0]  mem_addr;
    logic         mem_we;
    logic [3:0]   mem_be;
    logic [31:0]  mem_wdata;
    logic         result_valid;
    logic [31:0]  rdata;
    logic [4:0]   vreg_rd_addr;
    logic [127:0] vreg_rd;
    logic         vreg_wr_en;
    logic [4:0]   vreg_wr_addr;
    logic [15:0]  vreg_wr_be;
    logic [127:0] vreg_wr;
    logic         trans_complete;
    logic         stall_en;

    logic [127:0] vreg_rf [32];
    logic [31:0]  vec [MAX_WORDS];
    int           errors   = 0;
    int           n_ops    = 0;
    int           n_issued = 0;
    int           done_cnt = 0;
    bit           scan_done = 1'b0;

    vector_lsu i_dut (
        .clk_i (clk), .async_rst_ni (rst_n),
        .op_rdy_i (op_rdy), .op_ack_o (op_ack),
        .store_i (store), .stride_mode_i (stride_mode),
        .eew_i (eew), .emul_i (emul), .vl_i (vl),
        .base_i (base), .stride_i (stride), .vd_i (vd),
        .mem_valid_o (mem_valid), .mem_ready_i (mem_ready),
        .mem_addr_o (mem_addr), .mem_we_o (mem_we),
        .mem_be_o (mem_be), .mem_wdata_o (mem_wdata),
        .mem_result_valid_i (result_valid), .mem_rdata_i (rdata),
        .vreg_rd_addr_o (vreg_rd_addr), .vreg_rd_i (vreg_rd),
        .vreg_wr_en_o (vreg_wr_en), .vreg_wr_addr_o (vreg_wr_addr),
        .vreg_wr_be_o (vreg_wr_be), .vreg_wr_o (vreg_wr),
        .trans_complete_o (trans_complete)
    );

    tb_mem_model i_mem (
        .clk_i (clk), .stall_en_i (stall_en),
        .mem_valid_i (mem_valid), .mem_addr_i (mem_addr),
        .mem_we_i (mem_we), .mem_be_i (mem_be), .mem_wdata_i (mem_wdata),
        .mem_ready_o (mem_ready), .result_valid_o (result_valid), .rdata_o (rdata)
    );

    assign vreg_rd = vreg_rf[vreg_rd_addr];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        if (vreg_wr_en) begin
            for (int b = 0; b < 16; b++) begin
                if (vreg_wr_be[b]) begin
                    vreg_rf[vreg_wr_addr][b*8 +: 8] <= vreg_wr[b*8 +: 8];
                end
            end
        end
        if (trans_complete) begin
            done_cnt <= done_cnt + 1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // helpers

    // counts operation records and skips the others by their tag length
    function automatic int count_ops();
        int p;
        int n;
        p = 0;
        n = 0;
        while ((p < MAX_WORDS) && (vec[p] != 0)) begin
            case (vec[p])
                1, 5:    p += 3;
                2, 4:    p += 4;
                3: begin
                    n++;
                    p += 10;
                end
                default: p = MAX_WORDS;
            endcase
        end
        return n;
    endfunction

    task automatic issue_op(input int p);
        stall_en    = vec[p+9][0];
        store       = vec[p+1][0];
        stride_mode = vec[p+2][0];
        eew         = vec[p+3][1:0];
        emul        = vec[p+4][1:0];
        vl          = vec[p+5][6:0];
        base        = vec[p+6];
        stride      = vec[p+7];
        vd          = vec[p+8][4:0];
        op_rdy      = 1'b1;
        do begin
            @(negedge clk);
        end while (!op_ack);
        @(posedge clk);
        #1;
        op_rdy = 1'b0;
        n_issued++;
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
        end while (done_cnt != n_issued);
        #1;
    endtask

    task automatic check_reg(input int r, input int w, input logic [31:0] exp);
        assert (vreg_rf[r][w*32 +: 32] === exp) else begin
            $display("FAIL vreg_rf[%0d] word %0d: got %h expected %h",
                     r, w, vreg_rf[r][w*32 +: 32], exp);
            errors++;
        end
    endtask

    task automatic check_mem(input logic [7:0] a, input logic [31:0] exp);
        assert (i_mem.read_word(a) === exp) else begin
            $display("FAIL mem[%h]: got %h expected %h", a, i_mem.read_word(a), exp);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int p;
        op_rdy      = 1'b0;
        store       = 1'b0;
        stride_mode = 1'b0;
        eew         = '0;
        emul        = '0;
        vl          = '0;
        base        = '0;
        stride      = '0;
        vd          = '0;
        stall_en    = 1'b0;
        rst_n       = 1'b0;
        for (int r = 0; r < 32; r++) begin
            for (int b = 0; b < 16; b++) begin
                vreg_rf[r][b*8 +: 8] = 8'((r % 16) * 16 + b) ^ 8'((r / 16) * 128);
            end
        end
        $readmemh("lsu_input.txt", vec);
        n_ops     = count_ops();
        scan_done = 1'b1;

        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        assert (!op_ack && !mem_valid && !vreg_wr_en && !trans_complete) else begin
            $display("outputs not idle after reset");
            errors++;
        end

        p = 0;
        while (vec[p] != 0) begin
            case (vec[p])
                1: begin
                    i_mem.write_word(vec[p+1][7:0], vec[p+2]);
                    p += 3;
                end
                2: begin
                    vreg_rf[vec[p+1]][vec[p+2]*32 +: 32] = vec[p+3];
                    p += 4;
                end
                3: begin
                    issue_op(p);
                    p += 10;
                end
                4: begin
                    wait_idle();
                    check_reg(vec[p+1], vec[p+2], vec[p+3]);
                    p += 4;
                end
                5: begin
                    wait_idle();
                    check_mem(vec[p+1][7:0], vec[p+2]);
                    p += 3;
                end
                default: begin
                    $display("unknown record tag %h at word %0d", vec[p], p);
                    errors++;
                    break;
                end
            endcase
        end

        wait_idle();
        // idle a while so that a stray completion pulse would be counted
        repeat (10) @(posedge clk);
        #1;
        assert (done_cnt == n_ops) else begin
            $display("FAIL trans_complete_o count: got %h expected %h", done_cnt, n_ops);
            errors++;
        end

        $display("summary: %0d errors, %0d operations, %0d completions",
                 errors, n_ops, done_cnt);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog allows 200 cycles per operation
    initial begin
        wait (scan_done);
        repeat (200 * n_ops + 20) @(posedge clk);
        $display("timeout: operations did not complete in time");
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_mem_model.sv ====
/* byte-addressed memory model of 256 bytes that ignores the higher address bits
   results return in request order with stalls and delays only while stall_en_i is high */
`default_nettype none

module tb_mem_model (
    input  wire         clk_i,
    input  wire         stall_en_i,
    input  wire         mem_valid_i,
    input  wire  [31:0] mem_addr_i,
    input  wire         mem_we_i,
    input  wire  [3:0]  mem_be_i,
    input  wire  [31:0] mem_wdata_i,
    output logic        mem_ready_o,
    output logic        result_valid_o,
    output logic [31:0] rdata_o
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]  mem [256];
    logic [31:0] rdata_fifo [$];
    int          due_fifo [$];
    int          cyc;
    integer      seed;
    logic [31:0] rnd;
    logic        stall;

    task automatic write_word(input logic [7:0] addr, input logic [31:0] data);
        for (int k = 0; k < 4; k++) begin
            mem[8'(addr + k)] = data[k*8 +: 8];
        end
    endtask

    function automatic logic [31:0] read_word(input logic [7:0] addr);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[k*8 +: 8] = mem[8'(addr + k)];
        end
        return w;
    endfunction

    initial begin
        seed           = 32'h4fb5_d97b;
        cyc            = 0;
        stall          = 1'b0;
        mem_ready_o    = 1'b1;
        result_valid_o = 1'b0;
        rdata_o        = '0;
        // each byte starts out holding its own address
        for (int a = 0; a < 256; a++) begin
            mem[a] = 8'(a);
        end
        forever begin
            @(posedge clk_i);
            cyc++;
            // stall setting for this cycle is taken at the edge
            stall = stall_en_i;
            if (mem_valid_i && mem_ready_o) begin
                for (int k = 0; k < 4; k++) begin
                    if (mem_we_i && mem_be_i[k]) begin
                        mem[8'(mem_addr_i[7:0] + k)] = mem_wdata_i[k*8 +: 8];
                    end
                end
                rdata_fifo.push_back(read_word(mem_addr_i[7:0]));
                rnd = $random(seed);
                due_fifo.push_back(cyc + (stall ? int'(rnd[1:0]) : 0));
            end
            #1;
            rnd            = $random(seed);
            mem_ready_o    = stall ? rnd[0] : 1'b1;
            result_valid_o = 1'b0;
            // only the oldest request may answer
            if ((due_fifo.size() > 0) && (due_fifo[0] <= cyc)) begin
                void'(due_fifo.pop_front());
                rdata_o        = rdata_fifo.pop_front();
                result_valid_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== vector_lsu.sv ====
/* vector load/store unit top, one operation at a time on the request side
   up to four requests in flight, results return in order without back-pressure */
`default_nettype none

module vector_lsu (
    input  wire                            clk_i,
    input  wire                            async_rst_ni,
    input  wire                            op_rdy_i,
    output logic                           op_ack_o,
    input  wire                            store_i,
    input  wire                            stride_mode_i,
    input  wire  [1:0]                     eew_i,
    input  wire  [1:0]                     emul_i,
    input  wire  [lsu_pkg::VL_W-1:0]       vl_i,
    input  wire  [31:0]                    base_i,
    input  wire  [31:0]                    stride_i,
    input  wire  [lsu_pkg::VADDR_W-1:0]    vd_i,
    output logic                           mem_valid_o,
    input  wire                            mem_ready_i,
    output logic [31:0]                    mem_addr_o,
    output logic                           mem_we_o,
    output logic [lsu_pkg::VMEM_BYTES-1:0] mem_be_o,
    output logic [lsu_pkg::VMEM_W-1:0]     mem_wdata_o,
    input  wire                            mem_result_valid_i,
    input  wire  [lsu_pkg::VMEM_W-1:0]     mem_rdata_i,
    output logic [lsu_pkg::VADDR_W-1:0]    vreg_rd_addr_o,
    input  wire  [lsu_pkg::VREG_W-1:0]     vreg_rd_i,
    output logic                           vreg_wr_en_o,
    output logic [lsu_pkg::VADDR_W-1:0]    vreg_wr_addr_o,
    output logic [lsu_pkg::VREG_BYTES-1:0] vreg_wr_be_o,
    output logic [lsu_pkg::VREG_W-1:0]     vreg_wr_o,
    output logic                           trans_complete_o
);

    logic                        q_full;
    logic                        q_push;
    logic                        q_pop;
    logic [lsu_pkg::CNT_W-1:0]   q_cnt;
    logic [lsu_pkg::OFF_W-1:0]   q_off;
    logic                        q_store;
    logic                        q_stride;
    logic [1:0]                  q_eew;
    logic [lsu_pkg::VL_W-1:0]    q_vl;
    logic [lsu_pkg::VADDR_W-1:0] q_vd;
    logic                        q_last;
    // queue entry {cnt, off, store, stride, eew, vl, vd, last}
    logic [lsu_pkg::CNT_W+lsu_pkg::OFF_W+lsu_pkg::VL_W+lsu_pkg::VADDR_W+4:0] q_push_ctx;
    logic [lsu_pkg::CNT_W+lsu_pkg::OFF_W+lsu_pkg::VL_W+lsu_pkg::VADDR_W+4:0] q_pop_ctx;

    assign q_push_ctx = {q_cnt, q_off, q_store, q_stride, q_eew, q_vl, q_vd, q_last};

    lsu_addr_gen i_addr_gen (
        .clk_i          (clk_i),
        .async_rst_ni   (async_rst_ni),
        .op_rdy_i       (op_rdy_i),
        .op_ack_o       (op_ack_o),
        .store_i        (store_i),
        .stride_mode_i  (stride_mode_i),
        .eew_i          (eew_i),
        .emul_i         (emul_i),
        .vl_i           (vl_i),
        .base_i         (base_i),
        .stride_i       (stride_i),
        .vd_i           (vd_i),
        .mem_valid_o    (mem_valid_o),
        .mem_ready_i    (mem_ready_i),
        .mem_addr_o     (mem_addr_o),
        .mem_we_o       (mem_we_o),
        .mem_be_o       (mem_be_o),
        .mem_wdata_o    (mem_wdata_o),
        .vreg_rd_addr_o (vreg_rd_addr_o),
        .vreg_rd_i      (vreg_rd_i),
        .q_full_i       (q_full),
        .q_push_o       (q_push),
        .q_cnt_o        (q_cnt),
        .q_off_o        (q_off),
        .q_store_o      (q_store),
        .q_stride_o     (q_stride),
        .q_eew_o        (q_eew),
        .q_vl_o         (q_vl),
        .q_vd_o         (q_vd),
        .q_last_o       (q_last)
    );

    lsu_req_queue #(
        .CTX_W ($bits(q_push_ctx))
    ) i_req_queue (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .push_i       (q_push),
        .push_data_i  (q_push_ctx),
        .full_o       (q_full),
        .pop_i        (q_pop),
        .pop_data_o   (q_pop_ctx)
    );

    lsu_load_writeback i_writeback (
        .clk_i              (clk_i),
        .async_rst_ni       (async_rst_ni),
        .mem_result_valid_i (mem_result_valid_i),
        .mem_rdata_i        (mem_rdata_i),
        .ctx_i              (q_pop_ctx),
        .pop_o              (q_pop),
        .vreg_wr_en_o       (vreg_wr_en_o),
        .vreg_wr_addr_o     (vreg_wr_addr_o),
        .vreg_wr_be_o       (vreg_wr_be_o),
        .vreg_wr_o          (vreg_wr_o),
        .trans_complete_o   (trans_complete_o)
    );

endmodule

`default_nettype wire

// ==== lsu_load_writeback.sv ====
/* turns each memory result into one byte-masked register write a cycle later
   results of stores only advance the queue and completion */
`default_nettype none

module lsu_load_writeback (
    input  wire                            clk_i,
    input  wire                            async_rst_ni,
    input  wire                            mem_result_valid_i,
    input  wire  [lsu_pkg::VMEM_W-1:0]     mem_rdata_i,
    // {cnt, off, store, stride, eew, vl, vd, last}
    input  wire  [lsu_pkg::CNT_W+lsu_pkg::OFF_W+lsu_pkg::VL_W+lsu_pkg::VADDR_W+4:0] ctx_i,
    output logic                           pop_o,
    output logic                           vreg_wr_en_o,
    output logic [lsu_pkg::VADDR_W-1:0]    vreg_wr_addr_o,
    output logic [lsu_pkg::VREG_BYTES-1:0] vreg_wr_be_o,
    output logic [lsu_pkg::VREG_W-1:0]     vreg_wr_o,
    output logic                           trans_complete_o
);

    logic                                    valid_q;
    logic [lsu_pkg::VMEM_W-1:0]              rdata_q;
    lsu_pkg::lsu_counter_u                   cnt_q;
    logic [lsu_pkg::OFF_W-1:0]               off_q;
    logic                                    store_q;
    logic                                    stride_q;
    logic [1:0]                              eew_q;
    logic [lsu_pkg::VL_W-1:0]                vl_q;
    logic [lsu_pkg::VADDR_W-1:0]             vd_q;
    logic                                    last_q;
    logic [$clog2(lsu_pkg::VREG_BYTES)-1:0]  reg_byte;
    logic [lsu_pkg::VREG_BYTES-1:0]          sel;

    // results arrive in order, so the queue head belongs to this result
    assign pop_o = mem_result_valid_i;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= mem_result_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (mem_result_valid_i) begin
            rdata_q <= mem_rdata_i;
            {cnt_q, off_q, store_q, stride_q, eew_q, vl_q, vd_q, last_q} <= ctx_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // data placement

    assign reg_byte = {cnt_q.part.unit, cnt_q.part.stri};

    // data is replicated over the register, the enables pick the target bytes
    always_comb begin
        sel = '0;
        if ((stride_q == lsu_pkg::STRIDE_UNIT) || (eew_q == lsu_pkg::EEW_32)) begin
            vreg_wr_o = {lsu_pkg::UNIT_BEATS{rdata_q}};
            sel[reg_byte +: lsu_pkg::VMEM_BYTES] = '1;
        end else if (eew_q == lsu_pkg::EEW_16) begin
            vreg_wr_o = {(lsu_pkg::VREG_BYTES/2){rdata_q[off_q[lsu_pkg::OFF_W-1:1]*16 +: 16]}};
            sel[reg_byte +: 2] = '1;
        end else begin
            vreg_wr_o = {lsu_pkg::VREG_BYTES{rdata_q[off_q*8 +: 8]}};
            sel[reg_byte] = 1'b1;
        end
        // nothing beyond the last active byte of the group
        for (int j = 0; j < lsu_pkg::VREG_BYTES; j++) begin
            vreg_wr_be_o[j] = sel[j] & ((cnt_q.part.mul * lsu_pkg::VREG_BYTES + j) <= vl_q);
        end
    end

    assign vreg_wr_en_o     = valid_q & ~store_q;
    assign vreg_wr_addr_o   = vd_q;
    assign trans_complete_o = valid_q & last_q;

endmodule

`default_nettype wire

// ==== lsu_req_queue.sv ====
/* four-entry FIFO for request context, the depth must be a power of two
   pop data is valid whenever the FIFO holds an entry */
`default_nettype none

module lsu_req_queue #(
    parameter int unsigned CTX_W = 8
) (
    input  wire              clk_i,
    input  wire              async_rst_ni,
    input  wire              push_i,
    input  wire  [CTX_W-1:0] push_data_i,
    output logic             full_o,
    input  wire              pop_i,
    output logic [CTX_W-1:0] pop_data_o
);

    logic [CTX_W-1:0]                        mem_q [lsu_pkg::QUEUE_DEPTH];
    logic [$clog2(lsu_pkg::QUEUE_DEPTH)-1:0] wr_ptr_q;
    logic [$clog2(lsu_pkg::QUEUE_DEPTH)-1:0] rd_ptr_q;
    logic [$clog2(lsu_pkg::QUEUE_DEPTH):0]   count_q;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            unique case ({push_i, pop_i})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (push_i) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

    assign full_o     = (count_q == lsu_pkg::QUEUE_DEPTH);
    assign pop_data_o = mem_q[rd_ptr_q];

    // producer must respect full, results must match an issued request
    a_no_overflow: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        push_i |-> !full_o);

    a_no_underflow: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        pop_i |-> (count_q != '0));

endmodule

`default_nettype wire

// ==== lsu_addr_gen.sv ====
/* steps through a register group and issues one memory request per word or element
   strided addresses must be element aligned and unit-stride bases word aligned */
`default_nettype none

module lsu_addr_gen (
    input  wire                              clk_i,
    input  wire                              async_rst_ni,
    input  wire                              op_rdy_i,
    output logic                             op_ack_o,
    input  wire                              store_i,
    input  wire                              stride_mode_i,
    input  wire  [1:0]                       eew_i,
    input  wire  [1:0]                       emul_i,
    input  wire  [lsu_pkg::VL_W-1:0]         vl_i,
    input  wire  [31:0]                      base_i,
    input  wire  [31:0]                      stride_i,
    input  wire  [lsu_pkg::VADDR_W-1:0]      vd_i,
    output logic                             mem_valid_o,
    input  wire                              mem_ready_i,
    output logic [31:0]                      mem_addr_o,
    output logic                             mem_we_o,
    output logic [lsu_pkg::VMEM_BYTES-1:0]   mem_be_o,
    output logic [lsu_pkg::VMEM_W-1:0]       mem_wdata_o,
    output logic [lsu_pkg::VADDR_W-1:0]      vreg_rd_addr_o,
    input  wire  [lsu_pkg::VREG_W-1:0]       vreg_rd_i,
    input  wire                              q_full_i,
    output logic                             q_push_o,
    output logic [lsu_pkg::CNT_W-1:0]        q_cnt_o,
    output logic [lsu_pkg::OFF_W-1:0]        q_off_o,
    output logic                             q_store_o,
    output logic                             q_stride_o,
    output logic [1:0]                       q_eew_o,
    output logic [lsu_pkg::VL_W-1:0]         q_vl_o,
    output logic [lsu_pkg::VADDR_W-1:0]      q_vd_o,
    output logic                             q_last_o
);

    logic                                    active_q;
    logic                                    store_q;
    logic                                    stride_q;
    logic [1:0]                              eew_q;
    logic [1:0]                              emul_q;
    logic [lsu_pkg::VL_W-1:0]                vl_q;
    logic [31:0]                             addr_q;
    logic [31:0]                             stride_val_q;
    logic [lsu_pkg::VADDR_W-1:0]             vd_q;
    lsu_pkg::lsu_counter_u                   cnt_q;
    lsu_pkg::lsu_counter_u                   cnt_nxt;
    logic [lsu_pkg::CNT_W-1:0]               step;
    logic                                    grp_wrap;
    logic                                    last;
    logic                                    xfer;
    logic [$clog2(lsu_pkg::VREG_BYTES)-1:0]  reg_byte;
    logic [lsu_pkg::VMEM_BYTES-1:0]          be_elem;

    ////////////////////////////////////////////////////////////////////////////
    // counter stepping

    // one word per beat for unit stride, one element otherwise
    always_comb begin
        step = '0;
        if (stride_q == lsu_pkg::STRIDE_UNIT) begin
            step[lsu_pkg::STRI_W] = 1'b1;
        end else begin
            step[eew_q] = 1'b1;
        end
    end

    assign cnt_nxt.val = cnt_q.val + step;
    // next beat starts a new register
    assign grp_wrap    = ({cnt_nxt.part.unit, cnt_nxt.part.stri} == '0);

    always_comb begin
        unique case (emul_q)
            lsu_pkg::EMUL_1: last = grp_wrap;
            lsu_pkg::EMUL_2: last = grp_wrap & (cnt_nxt.part.mul[0] == 1'b0);
            lsu_pkg::EMUL_4: last = grp_wrap & (cnt_nxt.part.mul[1:0] == '0);
            lsu_pkg::EMUL_8: last = grp_wrap & (cnt_nxt.part.mul == '0);
        endcase
    end

    assign xfer        = mem_valid_o & mem_ready_i;
    assign mem_valid_o = active_q & ~q_full_i;
    // take the next operation while the final beat of this one goes out
    assign op_ack_o    = op_rdy_i & (~active_q | (last & xfer));

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            active_q <= 1'b0;
        end else if (op_ack_o) begin
            active_q <= 1'b1;
        end else if (xfer & last) begin
            active_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (op_ack_o) begin
            store_q      <= store_i;
            stride_q     <= stride_mode_i;
            eew_q        <= eew_i;
            emul_q       <= emul_i;
            vl_q         <= vl_i;
            stride_val_q <= stride_i;
            addr_q       <= base_i;
            vd_q         <= vd_i;
            cnt_q.val    <= '0;
        end else if (xfer) begin
            cnt_q <= cnt_nxt;
            if (stride_q == lsu_pkg::STRIDE_UNIT) begin
                addr_q <= addr_q + 32'(step);
            end else begin
                addr_q <= addr_q + stride_val_q;
            end
            if (grp_wrap) begin
                vd_q <= vd_q + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request fields

    assign reg_byte       = {cnt_q.part.unit, cnt_q.part.stri};
    assign vreg_rd_addr_o = vd_q;
    assign mem_addr_o     = {addr_q[31:lsu_pkg::OFF_W], {lsu_pkg::OFF_W{1'b0}}};
    assign mem_we_o       = store_q;

    always_comb begin
        be_elem = '1;
        if (stride_q == lsu_pkg::STRIDE_UNIT) begin
            mem_wdata_o = vreg_rd_i[reg_byte*8 +: lsu_pkg::VMEM_W];
            // byte j of the word sits at group index cnt + j
            for (int j = 0; j < lsu_pkg::VMEM_BYTES; j++) begin
                mem_be_o[j] = (cnt_q.val + j) <= vl_q;
            end
        end else begin
            // element is copied to every lane, enables pick the addressed one
            unique case (eew_q)
                lsu_pkg::EEW_8: begin
                    mem_wdata_o = {lsu_pkg::VMEM_BYTES{vreg_rd_i[reg_byte*8 +: 8]}};
                    be_elem     = 'b1;
                end
                lsu_pkg::EEW_16: begin
                    mem_wdata_o = {(lsu_pkg::VMEM_BYTES/2){vreg_rd_i[reg_byte*8 +: 16]}};
                    be_elem     = 'b11;
                end
                default: begin
                    mem_wdata_o = vreg_rd_i[reg_byte*8 +: lsu_pkg::VMEM_W];
                end
            endcase
            mem_be_o = (cnt_q.val <= vl_q) ? (be_elem << addr_q[lsu_pkg::OFF_W-1:0]) : '0;
        end
    end

    // context that travels with the request
    assign q_push_o   = xfer;
    assign q_cnt_o    = cnt_q.val;
    assign q_off_o    = addr_q[lsu_pkg::OFF_W-1:0];
    assign q_store_o  = store_q;
    assign q_stride_o = stride_q;
    assign q_eew_o    = eew_q;
    assign q_vl_o     = vl_q;
    assign q_vd_o     = vd_q;
    assign q_last_o   = last;

    ////////////////////////////////////////////////////////////////////////////
    // checks

    // an element never straddles two memory words
    a_elem_aligned: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        mem_valid_o |->
            ((addr_q[lsu_pkg::OFF_W-1:0] & (step[lsu_pkg::OFF_W-1:0] - 1'b1)) == '0));

    a_unit_base: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        op_ack_o && (stride_mode_i == lsu_pkg::STRIDE_UNIT) |->
            (base_i[lsu_pkg::OFF_W-1:0] == '0));

    a_req_hold: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o));

endmodule

`default_nettype wire

// ==== lsu_pkg.sv ====
/* widths, encodings and the step counter of the vector load/store unit
   memory port is one 32-bit word, registers are 128 bits, groups hold up to 8 registers */
`default_nettype none

package lsu_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // widths

    localparam int unsigned VREG_W      = 128;
    localparam int unsigned VMEM_W      = 32;
    localparam int unsigned VMEM_BYTES  = VMEM_W / 8;
    localparam int unsigned VREG_BYTES  = VREG_W / 8;
    localparam int unsigned VL_W        = 7;
    localparam int unsigned VADDR_W     = 5;
    localparam int unsigned OFF_W       = $clog2(VMEM_BYTES);
    localparam int unsigned UNIT_BEATS  = VREG_W / VMEM_W;
    localparam int unsigned STRI_W      = $clog2(VMEM_BYTES);
    // 3 register bits, then word within register, then byte within word
    localparam int unsigned CNT_W       = 3 + $clog2(UNIT_BEATS) + STRI_W;
    localparam int unsigned QUEUE_DEPTH = 4;

    ////////////////////////////////////////////////////////////////////////////
    // operation codes

    // element width, the code is log2 of the element size in bytes
    localparam logic [1:0] EEW_8  = 2'd0;
    localparam logic [1:0] EEW_16 = 2'd1;
    localparam logic [1:0] EEW_32 = 2'd2;

    // registers per group
    localparam logic [1:0] EMUL_1 = 2'd0;
    localparam logic [1:0] EMUL_2 = 2'd1;
    localparam logic [1:0] EMUL_4 = 2'd2;
    localparam logic [1:0] EMUL_8 = 2'd3;

    localparam logic STRIDE_UNIT  = 1'b0;
    localparam logic STRIDE_CONST = 1'b1;

    ////////////////////////////////////////////////////////////////////////////
    // step counter

    // val is the byte index inside the register group
    // part splits the same bits into register, word and byte
    typedef union packed {
        logic [CNT_W-1:0] val;
        struct packed {
            logic [2:0]                    mul;
            logic [$clog2(UNIT_BEATS)-1:0] unit;
            logic [STRI_W-1:0]             stri;
        } part;
    } lsu_counter_u;

endpackage

`default_nettype wire
